//--- rtl/hpm_defs.svh
`ifndef HPM_DEFS_SVH
`define HPM_DEFS_SVH

// Monitor geometry
`define HPM_NUM_COUNTERS 6
`define HPM_NUM_EVENTS 16
`define HPM_COMMIT_PORTS 2
`define HPM_XLEN 32

// CSR bases, counter 3 sits at the base itself
`define HPM_CSR_MCOUNTER_BASE 12'hB03
`define HPM_CSR_MCOUNTERH_BASE 12'hB83
`define HPM_CSR_MEVENT_BASE 12'h323
`define HPM_CSR_UCOUNTER_BASE 12'hC03
`define HPM_CSR_UCOUNTERH_BASE 12'hC83

// Event codes, also the bit index in the event vector
`define HPM_EV_NONE 0
`define HPM_EV_ICACHE_MISS 1
`define HPM_EV_DCACHE_MISS 2
`define HPM_EV_ITLB_MISS 3
`define HPM_EV_DTLB_MISS 4
`define HPM_EV_LOAD 5
`define HPM_EV_STORE 6
`define HPM_EV_EXCEPTION 7
`define HPM_EV_ERET 8
`define HPM_EV_BRANCH 9
`define HPM_EV_MISPREDICT 10
`define HPM_EV_CALL 11
`define HPM_EV_RETURN 12
`define HPM_EV_SB_FULL 13
`define HPM_EV_IF_EMPTY 14
`define HPM_EV_INT 15
`define HPM_EV_FLOAT 16

// Functional unit codes from the commit stage
`define HPM_FU_LOAD 4'd1
`define HPM_FU_STORE 4'd2
`define HPM_FU_ALU 4'd3
`define HPM_FU_CTRL_FLOW 4'd4
`define HPM_FU_MULT 4'd5
`define HPM_FU_FPU 4'd7

// Op codes used for call and return detection
`define HPM_OP_ADD 7'd0
`define HPM_OP_JALR 7'd30

`endif

//--- rtl/hpm_pkg.sv
`default_nettype none

`include "hpm_defs.svh"

package hpm_pkg;

  // CSR side
  typedef logic [11:0] csr_addr_t;
  typedef logic [`HPM_XLEN-1:0] xlen_t;

  // Counter storage and event selection
  typedef logic [63:0] counter_t;
  typedef logic [4:0] event_sel_t;
  typedef logic [`HPM_NUM_EVENTS:0] event_vec_t;  // Code 0 up to float

  // Commit stage fields
  typedef logic [3:0] fu_t;
  typedef logic [6:0] op_t;
  typedef logic [4:0] reg_idx_t;

  // Request port sequencing
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESPOND,
    RELEASE
  } port_state_t;

endpackage

`default_nettype wire

//--- rtl/hpm_csr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface hpm_csr_if;

  logic              strobe;  // One cycle per access
  hpm_pkg::csr_addr_t addr;
  logic              we;
  hpm_pkg::xlen_t    wdata;
  hpm_pkg::xlen_t    rdata;   // Answered in the strobe cycle
  logic              err;

  modport port (
    output strobe,
    output addr,
    output we,
    output wdata,
    input  rdata,
    input  err
  );

  modport bank (
    input  strobe,
    input  addr,
    input  we,
    input  wdata,
    output rdata,
    output err
  );

endinterface

`default_nettype wire

//--- rtl/hpm_csr_port.sv
`timescale 1ns/1ps
`default_nettype none

module hpm_csr_port (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  hpm_pkg::csr_addr_t addr_i,
  input  logic               we_i,
  input  hpm_pkg::xlen_t     wdata_i,
  output logic               ack_o,
  output hpm_pkg::xlen_t     rdata_o,
  output logic               err_o,
  hpm_csr_if.port            bus
);

  hpm_pkg::port_state_t state_q;

  // Request fields held for the bank
  hpm_pkg::csr_addr_t addr_q;
  logic               we_q;
  hpm_pkg::xlen_t     wdata_q;

  // Response registers
  hpm_pkg::xlen_t rdata_q;
  logic           ack_q;
  logic           err_q;

  logic take_req;

  assign take_req = (state_q == hpm_pkg::IDLE) && req_i;

  // Handshake sequencing
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= hpm_pkg::IDLE;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        hpm_pkg::IDLE: begin
          if (req_i) state_q <= hpm_pkg::ACCESS;
        end
        hpm_pkg::ACCESS: begin
          ack_q   <= 1'b1;     // Two edges after req seen
          err_q   <= bus.err;
          state_q <= hpm_pkg::RESPOND;
        end
        hpm_pkg::RESPOND: begin
          // Held here as long as the requester keeps req up
          if (!req_i) begin
            ack_q   <= 1'b0;
            state_q <= hpm_pkg::RELEASE;
          end
        end
        hpm_pkg::RELEASE: begin
          state_q <= hpm_pkg::IDLE;
        end
        default: begin
          state_q <= hpm_pkg::IDLE;
        end
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge clk_i) begin
    if (take_req) begin
      addr_q  <= addr_i;
      we_q    <= we_i;
      wdata_q <= wdata_i;
    end
    if (state_q == hpm_pkg::ACCESS) begin
      rdata_q <= bus.rdata;  // Stable until the next access
    end
  end

  assign bus.strobe = (state_q == hpm_pkg::ACCESS);
  assign bus.addr   = addr_q;
  assign bus.we     = we_q;
  assign bus.wdata  = wdata_q;

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;
  assign err_o   = err_q;

endmodule

`default_nettype wire

//--- rtl/hpm_event_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "hpm_defs.svh"

module hpm_event_decode (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  logic [`HPM_COMMIT_PORTS-1:0]                   commit_valid_i,
  input  hpm_pkg::fu_t [`HPM_COMMIT_PORTS-1:0]           commit_fu_i,
  input  hpm_pkg::op_t [`HPM_COMMIT_PORTS-1:0]           commit_op_i,
  input  hpm_pkg::reg_idx_t [`HPM_COMMIT_PORTS-1:0]      commit_rd_i,
  input  logic                                           icache_miss_i,
  input  logic                                           dcache_miss_i,
  input  logic                                           itlb_miss_i,
  input  logic                                           dtlb_miss_i,
  input  logic                                           exception_i,
  input  logic                                           eret_i,
  input  logic                                           mispredict_i,
  input  logic                                           sb_full_i,
  input  logic                                           if_empty_i,
  output hpm_pkg::event_vec_t                            events_o
);

  // Per-port classes
  logic [`HPM_COMMIT_PORTS-1:0] load_ev;
  logic [`HPM_COMMIT_PORTS-1:0] store_ev;
  logic [`HPM_COMMIT_PORTS-1:0] branch_ev;
  logic [`HPM_COMMIT_PORTS-1:0] call_ev;
  logic [`HPM_COMMIT_PORTS-1:0] return_ev;
  logic [`HPM_COMMIT_PORTS-1:0] int_ev;
  logic [`HPM_COMMIT_PORTS-1:0] fp_ev;

  hpm_pkg::event_vec_t events_d;
  hpm_pkg::event_vec_t events_q;

  always_comb begin
    for (int p = 0; p < `HPM_COMMIT_PORTS; p++) begin
      load_ev[p]   = commit_valid_i[p] && (commit_fu_i[p] == `HPM_FU_LOAD);
      store_ev[p]  = commit_valid_i[p] && (commit_fu_i[p] == `HPM_FU_STORE);
      branch_ev[p] = commit_valid_i[p] && (commit_fu_i[p] == `HPM_FU_CTRL_FLOW);
      // Link register x1 or x5 marks a call, jal decodes as ADD
      call_ev[p]   = branch_ev[p]
                     && ((commit_op_i[p] == `HPM_OP_ADD) || (commit_op_i[p] == `HPM_OP_JALR))
                     && ((commit_rd_i[p] == 5'd1) || (commit_rd_i[p] == 5'd5));
      return_ev[p] = commit_valid_i[p] && (commit_op_i[p] == `HPM_OP_JALR)
                     && (commit_rd_i[p] == 5'd0);
      int_ev[p]    = commit_valid_i[p]
                     && ((commit_fu_i[p] == `HPM_FU_ALU) || (commit_fu_i[p] == `HPM_FU_MULT));
      fp_ev[p]     = commit_valid_i[p] && (commit_fu_i[p] == `HPM_FU_FPU);
    end
  end

  // Merge by event code, both ports in one cycle count once
  always_comb begin
    events_d                         = '0;
    events_d[`HPM_EV_NONE]           = 1'b0;
    events_d[`HPM_EV_ICACHE_MISS]    = icache_miss_i;
    events_d[`HPM_EV_DCACHE_MISS]    = dcache_miss_i;
    events_d[`HPM_EV_ITLB_MISS]      = itlb_miss_i;
    events_d[`HPM_EV_DTLB_MISS]      = dtlb_miss_i;
    events_d[`HPM_EV_LOAD]           = |load_ev;
    events_d[`HPM_EV_STORE]          = |store_ev;
    events_d[`HPM_EV_EXCEPTION]      = exception_i;
    events_d[`HPM_EV_ERET]           = eret_i;
    events_d[`HPM_EV_BRANCH]         = |branch_ev;
    events_d[`HPM_EV_MISPREDICT]     = mispredict_i;
    events_d[`HPM_EV_CALL]           = |call_ev;
    events_d[`HPM_EV_RETURN]         = |return_ev;
    events_d[`HPM_EV_SB_FULL]        = sb_full_i;
    events_d[`HPM_EV_IF_EMPTY]       = if_empty_i;
    events_d[`HPM_EV_INT]            = |int_ev;
    events_d[`HPM_EV_FLOAT]          = |fp_ev;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) events_q <= '0;
    else          events_q <= events_d;  // New vector every cycle
  end

  assign events_o = events_q;

endmodule

`default_nettype wire

//--- rtl/hpm_counter_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "hpm_defs.svh"

module hpm_counter_bank (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          clear_i,
  input  logic                          debug_mode_i,
  input  logic [`HPM_NUM_COUNTERS-1:0]  inhibit_i,  // Bit 0 is counter 3
  input  hpm_pkg::event_vec_t           events_i,
  hpm_csr_if.bank                       bus
);

  hpm_pkg::counter_t   cnt_q [`HPM_NUM_COUNTERS];
  hpm_pkg::event_sel_t sel_q [`HPM_NUM_COUNTERS];

  // Address hits per counter
  logic [`HPM_NUM_COUNTERS-1:0] hit_mlo;
  logic [`HPM_NUM_COUNTERS-1:0] hit_mhi;
  logic [`HPM_NUM_COUNTERS-1:0] hit_sel;
  logic [`HPM_NUM_COUNTERS-1:0] hit_ulo;
  logic [`HPM_NUM_COUNTERS-1:0] hit_uhi;

  logic [`HPM_NUM_COUNTERS-1:0] cnt_inc;
  logic                         wr_strobe;
  logic                         rd_hit;
  logic                         wr_hit;

  assign wr_strobe = bus.strobe && bus.we;

  always_comb begin
    for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin
      hit_mlo[k] = (bus.addr == hpm_pkg::csr_addr_t'(`HPM_CSR_MCOUNTER_BASE + k));
      hit_mhi[k] = (bus.addr == hpm_pkg::csr_addr_t'(`HPM_CSR_MCOUNTERH_BASE + k));
      hit_sel[k] = (bus.addr == hpm_pkg::csr_addr_t'(`HPM_CSR_MEVENT_BASE + k));
      hit_ulo[k] = (bus.addr == hpm_pkg::csr_addr_t'(`HPM_CSR_UCOUNTER_BASE + k));
      hit_uhi[k] = (bus.addr == hpm_pkg::csr_addr_t'(`HPM_CSR_UCOUNTERH_BASE + k));
    end
  end

  // Counting enable, codes above float select nothing
  always_comb begin
    for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin
      cnt_inc[k] = 1'b0;
      if (sel_q[k] <= hpm_pkg::event_sel_t'(`HPM_EV_FLOAT)) begin
        cnt_inc[k] = events_i[sel_q[k]] && !inhibit_i[k] && !debug_mode_i && !wr_strobe;
      end
    end
  end

  // Read mux and error
  always_comb begin
    bus.rdata = '0;
    for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin
      if (hit_mlo[k] || hit_ulo[k]) bus.rdata = cnt_q[k][31:0];
      if (hit_mhi[k] || hit_uhi[k]) bus.rdata = cnt_q[k][63:32];
      if (hit_sel[k])               bus.rdata = hpm_pkg::xlen_t'(sel_q[k]);
    end
    rd_hit  = |{hit_mlo, hit_mhi, hit_sel, hit_ulo, hit_uhi};
    wr_hit  = |{hit_mlo, hit_mhi, hit_sel};  // User aliases are read-only
    bus.err = bus.we ? !wr_hit : !rd_hit;
  end

  for (genvar k = 0; k < `HPM_NUM_COUNTERS; k++) begin : g_cnt
    always_ff @(posedge clk_i) begin
      if (!rst_n_i || clear_i) begin
        cnt_q[k] <= '0;
        sel_q[k] <= '0;
      end else begin
        if (wr_strobe && hit_mlo[k]) begin
          cnt_q[k][31:0] <= bus.wdata;
        end else if (wr_strobe && hit_mhi[k]) begin
          cnt_q[k][63:32] <= bus.wdata;
        end else if (cnt_inc[k]) begin
          cnt_q[k] <= cnt_q[k] + 64'd1;  // Carries into the high half
        end
        if (wr_strobe && hit_sel[k]) begin
          sel_q[k] <= bus.wdata[4:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/hpm_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hpm_defs.svh"

module hpm_top (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                                      clear_i,
  input  logic                                      debug_mode_i,
  input  logic [`HPM_NUM_COUNTERS-1:0]              inhibit_i,
  // CSR request side
  input  logic                                      csr_req_i,
  input  hpm_pkg::csr_addr_t                        csr_addr_i,
  input  logic                                      csr_we_i,
  input  hpm_pkg::xlen_t                            csr_wdata_i,
  output logic                                      csr_ack_o,
  output hpm_pkg::xlen_t                            csr_rdata_o,
  output logic                                      csr_err_o,
  // Commit stage
  input  logic [`HPM_COMMIT_PORTS-1:0]              commit_valid_i,
  input  hpm_pkg::fu_t [`HPM_COMMIT_PORTS-1:0]      commit_fu_i,
  input  hpm_pkg::op_t [`HPM_COMMIT_PORTS-1:0]      commit_op_i,
  input  hpm_pkg::reg_idx_t [`HPM_COMMIT_PORTS-1:0] commit_rd_i,
  // Raw core events
  input  logic                                      icache_miss_i,
  input  logic                                      dcache_miss_i,
  input  logic                                      itlb_miss_i,
  input  logic                                      dtlb_miss_i,
  input  logic                                      exception_i,
  input  logic                                      eret_i,
  input  logic                                      mispredict_i,
  input  logic                                      sb_full_i,
  input  logic                                      if_empty_i
);

  hpm_pkg::event_vec_t events;

  hpm_csr_if csr_bus ();

  hpm_csr_port u_csr_port (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (csr_req_i),
    .addr_i  (csr_addr_i),
    .we_i    (csr_we_i),
    .wdata_i (csr_wdata_i),
    .ack_o   (csr_ack_o),
    .rdata_o (csr_rdata_o),
    .err_o   (csr_err_o),
    .bus     (csr_bus.port)
  );

  hpm_event_decode u_event_decode (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .commit_valid_i (commit_valid_i),
    .commit_fu_i    (commit_fu_i),
    .commit_op_i    (commit_op_i),
    .commit_rd_i    (commit_rd_i),
    .icache_miss_i  (icache_miss_i),
    .dcache_miss_i  (dcache_miss_i),
    .itlb_miss_i    (itlb_miss_i),
    .dtlb_miss_i    (dtlb_miss_i),
    .exception_i    (exception_i),
    .eret_i         (eret_i),
    .mispredict_i   (mispredict_i),
    .sb_full_i      (sb_full_i),
    .if_empty_i     (if_empty_i),
    .events_o       (events)
  );

  hpm_counter_bank u_counter_bank (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .clear_i      (clear_i),
    .debug_mode_i (debug_mode_i),
    .inhibit_i    (inhibit_i),
    .events_i     (events),
    .bus          (csr_bus.bank)
  );

endmodule

`default_nettype wire

//--- sim/hpm_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "hpm_defs.svh"

module hpm_assert (
  input logic                              clk_i,
  input logic                              rst_n_i,
  input logic                              req_i,
  input logic                              ack_i,
  input logic                              strobe_i,
  input logic                              clear_i,
  input logic [64*`HPM_NUM_COUNTERS-1:0]   cnt_i  // Counter 3 in the low word
);

  int fail_cnt = 0;

  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_i) |-> req_i)
    else begin
      fail_cnt++;
      $error("ack rose without req");
    end

  a_strobe_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    strobe_i |=> !strobe_i)
    else begin
      fail_cnt++;
      $error("strobe held longer than one cycle");
    end

  a_ack_low_reset: assert property (@(posedge clk_i) !rst_n_i |=> !ack_i)
    else begin
      fail_cnt++;
      $error("ack high after reset");
    end

  for (genvar k = 0; k < `HPM_NUM_COUNTERS; k++) begin : g_cnt_chk
    a_cnt_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !strobe_i && !clear_i |=> (cnt_i[k*64 +: 64] - $past(cnt_i[k*64 +: 64])) <= 64'd1)
      else begin
        fail_cnt++;
        $error("counter %0d jumped without a strobe", k + 3);
      end
  end

endmodule

bind hpm_csr_port hpm_assert u_port_assert (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .req_i    (req_i),
  .ack_i    (ack_o),
  .strobe_i (bus.strobe),
  .clear_i  (1'b0),
  .cnt_i    ('0)
);

bind hpm_counter_bank hpm_assert u_bank_assert (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .req_i    (1'b0),
  .ack_i    (1'b0),
  .strobe_i (bus.strobe),
  .clear_i  (clear_i),
  .cnt_i    ({cnt_q[5], cnt_q[4], cnt_q[3], cnt_q[2], cnt_q[1], cnt_q[0]})
);

`default_nettype wire

//--- sim/tb_hpm.sv
`timescale 1ns/1ps
`default_nettype none

`include "hpm_defs.svh"

module tb_hpm;

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 16;
  localparam int ACK_TIMEOUT     = 20;  // Cycles allowed per handshake phase
  localparam int CYCLES_PER_LINE = 50;
  localparam string TRACE_FILE   = "sim/hpm_trace.txt";

  logic                                       clk = 1'b0;
  logic                                       rst_n;
  logic                                       clear;
  logic                                       debug_mode;
  logic [`HPM_NUM_COUNTERS-1:0]               inhibit;
  logic                                       csr_req;
  hpm_pkg::csr_addr_t                         csr_addr;
  logic                                       csr_we;
  hpm_pkg::xlen_t                             csr_wdata;
  logic                                       csr_ack;
  hpm_pkg::xlen_t                             csr_rdata;
  logic                                       csr_err;
  logic [`HPM_COMMIT_PORTS-1:0]               commit_valid;
  hpm_pkg::fu_t [`HPM_COMMIT_PORTS-1:0]       commit_fu;
  hpm_pkg::op_t [`HPM_COMMIT_PORTS-1:0]       commit_op;
  hpm_pkg::reg_idx_t [`HPM_COMMIT_PORTS-1:0]  commit_rd;
  logic [8:0]                                 raw_ev;  // Bit 0 icache up to bit 8 fetch empty

  integer seed;
  int     errors = 0;
  int     checks = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     cur_test = 0;
  int     test_err_start = 0;
  string  lines[$];
  bit     trace_loaded = 1'b0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  hpm_top u_hpm_top (
    .clk_i (clk), .rst_n_i (rst_n), .clear_i (clear), .debug_mode_i (debug_mode),
    .inhibit_i (inhibit),
    .csr_req_i (csr_req), .csr_addr_i (csr_addr), .csr_we_i (csr_we),
    .csr_wdata_i (csr_wdata), .csr_ack_o (csr_ack), .csr_rdata_o (csr_rdata),
    .csr_err_o (csr_err),
    .commit_valid_i (commit_valid), .commit_fu_i (commit_fu),
    .commit_op_i (commit_op), .commit_rd_i (commit_rd),
    .icache_miss_i (raw_ev[0]), .dcache_miss_i (raw_ev[1]), .itlb_miss_i (raw_ev[2]),
    .dtlb_miss_i (raw_ev[3]), .exception_i (raw_ev[4]), .eret_i (raw_ev[5]),
    .mispredict_i (raw_ev[6]), .sb_full_i (raw_ev[7]), .if_empty_i (raw_ev[8])
  );

  task automatic init_inputs();
    rst_n        = 1'b0;
    clear        = 1'b0;
    debug_mode   = 1'b0;
    inhibit      = '0;
    csr_req      = 1'b0;
    csr_addr     = '0;
    csr_we       = 1'b0;
    csr_wdata    = '0;
    commit_valid = '0;
    commit_fu    = '0;
    commit_op    = '0;
    commit_rd    = '0;
    raw_ev       = '0;
    seed         = 32'h3bdf;
  endtask

  // Keeps data lines only, comments start with a lone #
  task automatic load_trace();
    int    fd;
    string line;
    string first;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("could not open trace file %s", TRACE_FILE);
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          if ($sscanf(line, "%s", first) == 1 && first != "#") lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic close_test();
    if (cur_test != 0) begin
      tests_run++;
      if (errors > test_err_start) begin
        tests_failed++;
        $display("test %0d: failed with %0d errors", cur_test, errors - test_err_start);
      end else begin
        $display("test %0d: passed", cur_test);
      end
    end
  endtask

  task automatic csr_access(input bit is_write, input hpm_pkg::csr_addr_t addr,
                            input hpm_pkg::xlen_t data, input bit exp_err);
    hpm_pkg::xlen_t got_data;
    logic           got_err;
    int             wait_cnt;
    bit             acked;
    if (!is_write) repeat (2) @(posedge clk);  // Pending increments land first
    repeat ({$random(seed)} % 4) @(posedge clk);
    @(posedge clk);
    csr_req   <= 1'b1;
    csr_addr  <= addr;
    csr_we    <= is_write;
    csr_wdata <= is_write ? data : '0;
    acked    = 1'b0;
    wait_cnt = 0;
    while (!acked && wait_cnt < ACK_TIMEOUT) begin
      @(negedge clk);
      acked = csr_ack;
      wait_cnt++;
    end
    got_data = csr_rdata;
    got_err  = csr_err;
    if (!acked) begin
      errors++;
      $display("no ack for the access to 0x%h within %0d cycles", addr, ACK_TIMEOUT);
    end else begin
      // Requester holds req, the response must not move
      repeat ({$random(seed)} % 8) begin
        @(negedge clk);
        checks++;
        if (!csr_ack || csr_rdata !== got_data) begin
          errors++;
          $display("FAIL %0t: response moved while req held, ack %b rdata 0x%h",
                   $time, csr_ack, csr_rdata);
        end
      end
    end
    @(posedge clk);
    csr_req <= 1'b0;
    wait_cnt = 0;
    do begin
      @(negedge clk);
      wait_cnt++;
    end while (csr_ack && wait_cnt < ACK_TIMEOUT);
    if (csr_ack) begin
      errors++;
      $display("ack for the access to 0x%h never dropped after req fell", addr);
    end
    if (acked) begin
      checks++;
      if (got_err !== exp_err) begin
        errors++;
        $display("FAIL %0t: err at 0x%h is %b, expected %b", $time, addr, got_err, exp_err);
      end
      if (!is_write) begin
        checks++;
        if (got_data !== data) begin
          errors++;
          $display("FAIL %0t: read 0x%h returned 0x%h, expected 0x%h",
                   $time, addr, got_data, data);
        end
      end
    end
  endtask

  task automatic drive_events(input logic [8:0] raw, input logic [1:0] valid,
                              input hpm_pkg::fu_t fu0, input hpm_pkg::op_t op0,
                              input hpm_pkg::reg_idx_t rd0, input hpm_pkg::fu_t fu1,
                              input hpm_pkg::op_t op1, input hpm_pkg::reg_idx_t rd1,
                              input int cycles);
    @(posedge clk);
    raw_ev       <= raw;
    commit_valid <= valid;
    commit_fu    <= {fu1, fu0};
    commit_op    <= {op1, op0};
    commit_rd    <= {rd1, rd0};
    repeat (cycles) @(posedge clk);  // Decode samples the pattern this many times
    raw_ev       <= '0;
    commit_valid <= '0;
    commit_fu    <= '0;
    commit_op    <= '0;
    commit_rd    <= '0;
  endtask

  task automatic apply_control(input logic [`HPM_NUM_COUNTERS-1:0] inh, input bit dbg,
                               input bit clr);
    @(posedge clk);
    inhibit    <= inh;
    debug_mode <= dbg;
    if (clr) begin
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
    end
  endtask

  task automatic run_line(input string line);
    string       op;
    int          test_no;
    int          cycles;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    logic [31:0] valid;
    logic [31:0] fu0, opc0, rd0, fu1, opc1, rd1;
    void'($sscanf(line, "%s %d", op, test_no));
    if (test_no != cur_test) begin
      close_test();
      cur_test       = test_no;
      test_err_start = errors;
    end
    if (op == "W" || op == "R") begin
      void'($sscanf(line, "%s %d %h %h %h", op, test_no, a, d, e));
      csr_access(op == "W", a[11:0], d, e[0]);
    end else if (op == "E") begin
      void'($sscanf(line, "%s %d %h %h %h %h %h %h %h %h %d", op, test_no, a, valid,
                    fu0, opc0, rd0, fu1, opc1, rd1, cycles));
      drive_events(a[8:0], valid[1:0], fu0[3:0], opc0[6:0], rd0[4:0], fu1[3:0],
                   opc1[6:0], rd1[4:0], cycles);
    end else if (op == "C") begin
      void'($sscanf(line, "%s %d %h %h %h", op, test_no, a, d, e));
      apply_control(a[`HPM_NUM_COUNTERS-1:0], d[0], e[0]);
    end else begin
      errors++;
      $display("trace line not understood: %s", line);
    end
  endtask

  initial begin
    init_inputs();
    load_trace();
    trace_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    foreach (lines[i]) run_line(lines[i]);
    close_test();
    errors += u_hpm_top.u_csr_port.u_port_assert.fail_cnt;
    errors += u_hpm_top.u_counter_bank.u_bank_assert.fail_cnt;
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Run length bound from the trace size
  initial begin
    longint limit_cycles;
    wait (trace_loaded);
    limit_cycles = RESET_CYCLES + CYCLES_PER_LINE * (lines.size() + 1);
    #(limit_cycles * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/hpm_trace.txt
# op test fields, hex unless noted. W and R: addr data err. C: inhibit debug clear
# E: raw{ifempty,sbfull,mispred,eret,exc,dtlb,itlb,dcache,icache} valid fu0 op0 rd0 fu1 op1 rd1 cycles
W 1 B03 11111103 0
W 1 B83 22222203 0
R 1 B03 11111103 0
R 1 B83 22222203 0
W 1 B04 11111104 0
W 1 B84 22222204 0
R 1 B04 11111104 0
R 1 B84 22222204 0
W 1 B05 11111105 0
W 1 B85 22222205 0
R 1 B05 11111105 0
R 1 B85 22222205 0
W 1 B06 11111106 0
W 1 B86 22222206 0
R 1 B06 11111106 0
R 1 B86 22222206 0
W 1 B07 11111107 0
W 1 B87 22222207 0
R 1 B07 11111107 0
R 1 B87 22222207 0
W 1 B08 11111108 0
W 1 B88 22222208 0
R 1 B08 11111108 0
R 1 B88 22222208 0
# Carry from the low half into the high half
W 1 323 FFFFFFE1 0
R 1 323 00000001 0
W 1 B03 FFFFFFFF 0
E 1 001 0 0 0 0 0 0 0 1
R 1 B03 00000000 0
R 1 B83 22222204 0
# Raw events, counter 7 on code 0 and counter 8 on an unused code
W 2 323 00000002 0
W 2 324 00000003 0
W 2 325 FFFFFF04 0
W 2 326 00000007 0
W 2 327 FFFFFFE0 0
W 2 328 FFFFFFFF 0
R 2 323 00000002 0
R 2 324 00000003 0
R 2 325 00000004 0
R 2 326 00000007 0
R 2 327 00000000 0
R 2 328 0000001F 0
E 2 1FF 0 0 0 0 0 0 0 5
R 2 B03 00000005 0
R 2 B04 11111109 0
R 2 B05 1111110A 0
R 2 B06 1111110B 0
R 2 B07 11111107 0
R 2 B08 11111108 0
# Commit classes: load store call return int branch
C 3 00 0 1
W 3 323 00000005 0
W 3 324 00000006 0
W 3 325 0000000B 0
W 3 326 0000000C 0
W 3 327 0000000F 0
W 3 328 00000009 0
E 3 000 3 1 0 0 1 0 0 3
E 3 000 1 2 0 0 1 0 0 2
E 3 000 3 4 0 1 4 1E 5 4
E 3 000 3 3 0 3 4 1E 0 2
E 3 000 3 5 0 1 7 0 0 3
R 3 B03 00000003 0
R 3 B04 00000002 0
R 3 B05 00000004 0
R 3 B06 00000002 0
R 3 B07 00000005 0
R 3 B08 00000006 0
# Inhibit, debug mode and clear
C 4 01 0 0
E 4 000 3 1 0 0 3 0 0 2
R 4 B03 00000003 0
R 4 B07 00000007 0
C 4 00 1 0
E 4 000 3 1 0 0 3 0 0 3
R 4 B03 00000003 0
R 4 B07 00000007 0
C 4 00 0 0
E 4 000 3 1 0 0 3 0 0 1
R 4 B03 00000004 0
R 4 B07 00000008 0
C 4 00 0 1
R 4 B03 00000000 0
R 4 B87 00000000 0
R 4 327 00000000 0
# User aliases and unmapped addresses
W 5 B05 0000ABCD 0
W 5 B85 00000012 0
R 5 C05 0000ABCD 0
R 5 C85 00000012 0
W 5 C05 FFFFFFFF 1
W 5 C85 FFFFFFFF 1
W 5 7C0 12345678 1
W 5 B09 12345678 1
R 5 B05 0000ABCD 0
R 5 B85 00000012 0
R 5 325 00000000 0
R 5 B09 00000000 1
R 5 B00 00000000 1
# Back-to-back accesses
W 6 B06 5A5A0006 0
W 6 B86 A5A50006 0
W 6 328 00000010 0
R 6 B06 5A5A0006 0
R 6 B86 A5A50006 0
R 6 328 00000010 0
R 6 C86 A5A50006 0
R 6 C06 5A5A0006 0

//--- all.f
+incdir+rtl
rtl/hpm_pkg.sv
rtl/hpm_csr_if.sv
rtl/hpm_csr_port.sv
rtl/hpm_event_decode.sv
rtl/hpm_counter_bank.sv
rtl/hpm_top.sv
sim/hpm_assert.sv
sim/tb_hpm.sv
